/* fetch_stage.f */
src/fetch_pkg.sv
src/fetch_control.sv
src/refill_counter.sv
src/icache_array.sv
src/fetch_datapath.sv
src/fetch_stage.sv
test/fetch_stage_assertions.sv
test/fetch_stage_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build with Verilator, run, and pass only when the pass line shows up.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module fetch_stage_tb \
	-f fetch_stage.f -o fetch_stage_sim &&
./obj_dir/fetch_stage_sim +verilator+error+limit+100 | tee /dev/stderr |
	grep -qx "Done: no errors" &&
echo "PASS" ||
{ echo "FAIL"; exit 1; }

/* test/fetch_stage_tb.sv */
`timescale 1ns/1ps

module fetch_stage_tb;

	localparam logic [31:0] reset_pc = 32'h3000_0000;
	localparam logic [31:0] cache_base = 32'ha000_0000;
	localparam logic [31:0] cache_limit = 32'ha200_0000;
	localparam int handshake_target = 600;
	localparam int cycle_limit = 40000;

	logic clock = 1'b0;
	logic reset = 1'b1;
	logic [31:0] mem_araddr;
	logic mem_arvalid;
	logic mem_arready;
	logic [1:0] mem_arburst;
	logic [3:0] mem_arlen;
	logic [31:0] mem_rdata;
	logic mem_rvalid;
	logic mem_rlast;
	logic [31:0] pc;
	logic [31:0] inst;
	logic idu_valid;
	logic idu_ready;
	logic jump_wrong;
	logic [31:0] jump_addr;

	logic [31:0] lfsr = 32'hec36f3c0;
	logic [31:0] beat_addr = '0; // Next word of the read being answered.
	int beats_left = 0;
	int target_kind = 0;
	int handshakes = 0;
	int cycles = 0;

	fetch_stage #(
		.reset_pc(reset_pc),
		.cache_base(cache_base),
		.cache_limit(cache_limit),
		.line_count(16)
	) u_fetch_stage (.*);

	always #20 clock = ~clock;

	// Fibonacci LFSR with taps 32, 22, 2 and 1. It steps once per bit.
	function automatic logic [31:0] random_bits(input int count);
		logic [31:0] value;
		logic feedback;
		value = '0;
		for (int i = 0; i < count; i++) begin
			feedback = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], feedback};
			value = {value[30:0], feedback};
		end
		return value;
	endfunction

	function automatic logic [31:0] mem_word(input logic [31:0] addr);
		return {addr[17:2], addr[31:16]} ^ 32'h6b8b_4567;
	endfunction

	// Cycles through a wide cached range, four reused lines and the uncached region.
	function automatic logic [31:0] pick_target();
		target_kind = (target_kind + 1) % 3;
		case (target_kind)
			0: return cache_base | (random_bits(12) << 2);
			1: return cache_base + (random_bits(2) << 6) + (random_bits(2) << 2);
			default: return reset_pc + (random_bits(6) << 2);
		endcase
	endfunction

	task automatic drive_read_channel();
		mem_rvalid = 1'b0;
		mem_rlast = 1'b0;
		if (beats_left != 0 && random_bits(2) != 32'd0) begin
			mem_rvalid = 1'b1;
			mem_rdata = mem_word(beat_addr);
			mem_rlast = (beats_left == 1);
			beat_addr = beat_addr + 32'd4;
			beats_left--;
		end
		mem_arready = 1'b0;
		if (mem_arvalid && beats_left == 0 && random_bits(2) != 32'd0) begin
			mem_arready = 1'b1; // Beats start the cycle after this handshake.
			beat_addr = mem_araddr;
			beats_left = mem_arlen + 1;
		end
	endtask

	task automatic drive_decode();
		if (!jump_wrong && handshakes != 0 && random_bits(5) == 32'd0) begin
			jump_wrong = 1'b1;
			jump_addr = pick_target();
		end else begin
			jump_wrong = 1'b0;
		end
		idu_ready = random_bits(2) != 32'd0;
		if (idu_valid && idu_ready && !jump_wrong) begin
			handshakes++;
		end
	endtask

	task automatic fail_run(input string reason);
		$display("Done: errors found");
		$fatal(1, "%s", reason);
	endtask

	initial begin
		mem_arready = 1'b0;
		mem_rdata = '0;
		mem_rvalid = 1'b0;
		mem_rlast = 1'b0;
		idu_ready = 1'b0;
		jump_wrong = 1'b0;
		jump_addr = '0;
		repeat (16) @(posedge clock);
		#2;
		reset = 1'b0;
		// One pass per clock. Inputs change 2 ns after the edge.
		while (u_fetch_stage.u_fetch_stage_assertions.error_count == 0 &&
			handshakes < handshake_target && cycles < cycle_limit) begin
			@(posedge clock);
			#2;
			cycles++;
			drive_read_channel();
			drive_decode();
		end
		// The last handshake completes and is checked at the next edge.
		@(posedge clock);
		#2;
		if (u_fetch_stage.u_fetch_stage_assertions.error_count != 0) begin
			fail_run("an assertion in the bound checker failed");
		end else if (handshakes < handshake_target) begin
			fail_run("timed out waiting for decode handshakes");
		end else begin
			$display("Done: no errors");
			$finish;
		end
	end

endmodule

/* test/fetch_stage_assertions.sv */
`timescale 1ns/1ps

module fetch_stage_assertions import fetch_pkg::*; #(
	parameter addr_t reset_pc = 32'h3000_0000,
	parameter addr_t cache_base = 32'ha000_0000,
	parameter addr_t cache_limit = 32'ha200_0000,
	parameter int line_count = 16
) (
	input  logic   clock,
	input  logic   reset,
	input  logic   lookup_en,
	input  addr_t  mem_araddr,
	input  logic   mem_arvalid,
	input  logic   mem_arready,
	input  burst_t mem_arburst,
	input  len_t   mem_arlen,
	input  logic   mem_rvalid,
	input  logic   mem_rlast,
	input  addr_t  pc,
	input  word_t  inst,
	input  logic   idu_valid,
	input  logic   idu_ready,
	input  logic   jump_wrong,
	input  addr_t  jump_addr
);

	localparam int index_bits = $clog2(line_count);

	int error_count = 0;
	addr_t expect_pc; // Next pc that decode should see.
	logic first_request;
	addr_t request_line;
	logic request_cached;
	addr_t shadow_line [line_count]; // Line address held by each cache slot.
	logic [line_count-1:0] shadow_valid;
	logic pc_cached;
	logic pc_hit;

	function automatic word_t expected_word(input addr_t addr);
		return {addr[17:2], addr[31:16]} ^ 32'h6b8b_4567;
	endfunction

	function automatic logic in_cache_window(input addr_t addr);
		return (addr >= cache_base) && (addr < cache_limit);
	endfunction

	assign pc_cached = in_cache_window(pc);
	assign pc_hit = pc_cached && shadow_valid[pc[4 +: index_bits]] &&
		(shadow_line[pc[4 +: index_bits]] == {pc[31:4], 4'h0});

	// ******************************
	// Reference model
	// ******************************

	always_ff @(posedge clock) begin
		if (reset) begin
			expect_pc <= reset_pc;
			first_request <= 1'b1;
			shadow_valid <= '0;
		end else begin
			if (jump_wrong) begin
				expect_pc <= jump_addr; // A redirect beats a handshake.
			end else if (idu_valid && idu_ready) begin
				expect_pc <= pc + 32'd4;
			end
			if (mem_arvalid) begin
				first_request <= 1'b0;
			end
			if (mem_arvalid && mem_arready) begin
				request_line <= mem_araddr;
				request_cached <= in_cache_window(mem_araddr);
			end
			// A line counts as present once its last beat has arrived.
			if (mem_rvalid && mem_rlast && request_cached) begin
				shadow_valid[request_line[4 +: index_bits]] <= 1'b1;
				shadow_line[request_line[4 +: index_bits]] <= request_line;
			end
		end
	end

	// ******************************
	// Reset and requests
	// ******************************

	reset_idle: assert property (@(posedge clock) reset |=> !mem_arvalid && !idu_valid)
		else begin
			error_count++;
			$error("read request or decode valid is high right after reset");
		end

	first_address: assert property (@(posedge clock) disable iff (reset)
		mem_arvalid && first_request |-> mem_araddr == reset_pc)
		else begin
			error_count++;
			$error("error mem_araddr %h expected %h", $sampled(mem_araddr), reset_pc);
		end

	request_form: assert property (@(posedge clock) disable iff (reset)
		$rose(mem_arvalid) |-> (pc_cached ?
		(mem_arburst == 2'd1 && mem_arlen == 4'd3 && mem_araddr == {pc[31:4], 4'h0}) :
		(mem_arburst == 2'd0 && mem_arlen == 4'd0 && mem_araddr == pc)))
		else begin
			error_count++;
			$error("error mem_araddr %h mem_arburst %h mem_arlen %h for pc %h",
				$sampled(mem_araddr), $sampled(mem_arburst), $sampled(mem_arlen),
				$sampled(pc));
		end

	request_hold: assert property (@(posedge clock) disable iff (reset)
		mem_arvalid && !mem_arready |=>
		mem_arvalid && $stable(mem_araddr) && $stable(mem_arburst) && $stable(mem_arlen))
		else begin
			error_count++;
			$error("read request dropped or changed before mem_arready");
		end

	// ******************************
	// Decode side
	// ******************************

	inst_value: assert property (@(posedge clock) disable iff (reset)
		idu_valid |-> inst == expected_word(pc))
		else begin
			error_count++;
			$error("error inst %h expected %h at pc %h", $sampled(inst),
				expected_word($sampled(pc)), $sampled(pc));
		end

	pc_order: assert property (@(posedge clock) disable iff (reset)
		idu_valid |-> pc == expect_pc)
		else begin
			error_count++;
			$error("error pc %h expected %h", $sampled(pc), $sampled(expect_pc));
		end

	deliver_hold: assert property (@(posedge clock) disable iff (reset)
		idu_valid && !idu_ready && !jump_wrong |=> idu_valid && $stable(pc) && $stable(inst))
		else begin
			error_count++;
			$error("instruction dropped or changed before idu_ready");
		end

	// Lookup, compare, then deliver, with no request in between.
	hit_latency: assert property (@(posedge clock) disable iff (reset)
		$past(lookup_en, 2) && $past(pc_hit, 2) && !$past(jump_wrong, 2) && !$past(jump_wrong)
		|-> idu_valid)
		else begin
			error_count++;
			$error("cache hit was not delivered two cycles after lookup");
		end

endmodule

bind fetch_stage fetch_stage_assertions #(
	.reset_pc(reset_pc),
	.cache_base(cache_base),
	.cache_limit(cache_limit),
	.line_count(line_count)
) u_fetch_stage_assertions (.*);

/* src/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage import fetch_pkg::*; #(
	parameter addr_t reset_pc = 32'h3000_0000,
	parameter addr_t cache_base = 32'ha000_0000,
	parameter addr_t cache_limit = 32'ha200_0000,
	parameter int line_count = 16
) (
	input  logic   clock,
	input  logic   reset,
	output addr_t  mem_araddr,
	output logic   mem_arvalid,
	input  logic   mem_arready,
	output burst_t mem_arburst,
	output len_t   mem_arlen,
	input  word_t  mem_rdata,
	input  logic   mem_rvalid,
	input  logic   mem_rlast,
	output addr_t  pc,
	output word_t  inst,
	output logic   idu_valid,
	input  logic   idu_ready,
	input  logic   jump_wrong,
	input  addr_t  jump_addr
);

	logic lookup_en;
	logic refill_start;
	logic inst_load_cache;
	logic inst_load_mem;
	logic pc_advance;
	logic in_window;
	logic hit;
	word_t cache_rdata;
	beat_t beat_index;
	logic beat_write;
	logic refill_done;
	addr_t fill_addr;

	// ******************************
	// Sequencing
	// ******************************

	fetch_control u_fetch_control (
		.clock(clock),
		.reset(reset),
		.in_window(in_window),
		.hit(hit),
		.mem_arready(mem_arready),
		.mem_rvalid(mem_rvalid),
		.refill_done(refill_done),
		.jump_wrong(jump_wrong),
		.idu_ready(idu_ready),
		.lookup_en(lookup_en),
		.refill_start(refill_start),
		.ar_issue(mem_arvalid), // The request valid comes straight from the state.
		.inst_load_cache(inst_load_cache),
		.inst_load_mem(inst_load_mem),
		.pc_advance(pc_advance),
		.idu_valid(idu_valid)
	);

	refill_counter u_refill_counter (
		.clock(clock),
		.reset(reset),
		.refill_start(refill_start),
		.mem_rvalid(mem_rvalid),
		.mem_rlast(mem_rlast),
		.beat_index(beat_index),
		.beat_write(beat_write),
		.refill_done(refill_done)
	);

	// ******************************
	// Storage and datapath
	// ******************************

	icache_array #(
		.line_count(line_count)
	) u_icache_array (
		.clock(clock),
		.reset(reset),
		.lookup_en(lookup_en),
		.lookup_addr(pc),
		.fill_addr(fill_addr),
		.beat_index(beat_index),
		.beat_write(beat_write),
		.fill_data(mem_rdata),
		.refill_done(refill_done),
		.hit(hit),
		.cache_rdata(cache_rdata)
	);

	fetch_datapath #(
		.reset_pc(reset_pc),
		.cache_base(cache_base),
		.cache_limit(cache_limit)
	) u_fetch_datapath (
		.clock(clock),
		.reset(reset),
		.lookup_en(lookup_en),
		.pc_advance(pc_advance),
		.jump_wrong(jump_wrong),
		.jump_addr(jump_addr),
		.inst_load_cache(inst_load_cache),
		.inst_load_mem(inst_load_mem),
		.cache_rdata(cache_rdata),
		.mem_rdata(mem_rdata),
		.beat_index(beat_index),
		.beat_write(beat_write),
		.pc(pc),
		.in_window(in_window),
		.fill_addr(fill_addr),
		.mem_araddr(mem_araddr),
		.mem_arburst(mem_arburst),
		.mem_arlen(mem_arlen),
		.inst(inst)
	);

endmodule

/* src/fetch_datapath.sv */
`timescale 1ns/1ps

module fetch_datapath import fetch_pkg::*; #(
	parameter addr_t reset_pc = 32'h3000_0000,
	parameter addr_t cache_base = 32'ha000_0000,
	parameter addr_t cache_limit = 32'ha200_0000
) (
	input  logic   clock,
	input  logic   reset,
	input  logic   lookup_en,
	input  logic   pc_advance,
	input  logic   jump_wrong,
	input  addr_t  jump_addr,
	input  logic   inst_load_cache,
	input  logic   inst_load_mem,
	input  word_t  cache_rdata,
	input  word_t  mem_rdata,
	input  beat_t  beat_index,
	input  logic   beat_write,
	output addr_t  pc,
	output logic   in_window,
	output addr_t  fill_addr,
	output addr_t  mem_araddr,
	output burst_t mem_arburst,
	output len_t   mem_arlen,
	output word_t  inst
);

	localparam int offset_bits = $bits(beat_t) + 2;

	addr_t req_addr; // Address of the fetch in flight.
	logic req_cached;
	logic beat_match;

	// ******************************
	// Program counter
	// ******************************

	always_ff @(posedge clock) begin
		if (reset) begin
			pc <= reset_pc;
		end else if (jump_wrong) begin
			pc <= jump_addr; // Redirect wins over a same-cycle handshake.
		end else if (pc_advance) begin
			pc <= pc + 32'd4;
		end
	end

	assign in_window = (pc >= cache_base) && (pc < cache_limit);

	// ******************************
	// Read request
	// ******************************

	// Snapshot taken at lookup, so a redirect does not disturb a pending read.
	always_ff @(posedge clock) begin
		if (lookup_en) begin
			req_addr <= pc;
			req_cached <= in_window;
		end
	end

	assign fill_addr = {req_addr[$bits(addr_t)-1:offset_bits], {offset_bits{1'b0}}};
	assign mem_araddr = req_cached ? fill_addr : req_addr;
	assign mem_arburst = req_cached ? burst_incr : burst_fixed;
	assign mem_arlen = req_cached ? line_len : '0; // Single beat outside the window.

	// A refill beat is kept only when it carries the word at pc.
	assign beat_match = !beat_write || (beat_index == pc[2 +: $bits(beat_t)]);

	always_ff @(posedge clock) begin
		if (inst_load_cache) begin
			inst <= cache_rdata;
		end else if (inst_load_mem && beat_match) begin
			inst <= mem_rdata;
		end
	end

endmodule

/* src/icache_array.sv */
`timescale 1ns/1ps

module icache_array import fetch_pkg::*; #(
	parameter int line_count = 16
) (
	input  logic  clock,
	input  logic  reset,
	input  logic  lookup_en,
	input  addr_t lookup_addr,
	input  addr_t fill_addr,
	input  beat_t beat_index,
	input  logic  beat_write,
	input  word_t fill_data,
	input  logic  refill_done,
	output logic  hit,
	output word_t cache_rdata
);

	localparam int offset_bits = $bits(beat_t) + 2;
	localparam int index_bits = $clog2(line_count);
	localparam int tag_bits = $bits(addr_t) - index_bits - offset_bits;
	localparam int words_per_line = 1 << $bits(beat_t);

	// ******************************
	// Storage
	// ******************************

	word_t data_mem [line_count][words_per_line];
	logic [tag_bits-1:0] tag_mem [line_count];
	logic [line_count-1:0] valid;

	logic [index_bits-1:0] lookup_index;
	logic [tag_bits-1:0] lookup_tag;
	beat_t lookup_word;
	logic [index_bits-1:0] fill_index;
	logic [tag_bits-1:0] fill_tag;

	// Registered copies of the lookup, compared one cycle later.
	logic [tag_bits-1:0] rd_tag;
	logic [tag_bits-1:0] cmp_tag;
	logic rd_valid;

	assign lookup_index = lookup_addr[offset_bits +: index_bits];
	assign lookup_tag = lookup_addr[$bits(addr_t)-1 -: tag_bits];
	assign lookup_word = lookup_addr[2 +: $bits(beat_t)];
	assign fill_index = fill_addr[offset_bits +: index_bits];
	assign fill_tag = fill_addr[$bits(addr_t)-1 -: tag_bits];

	// Words land one per beat. The tag goes in with the last one.
	always_ff @(posedge clock) begin
		if (beat_write) begin
			data_mem[fill_index][beat_index] <= fill_data;
		end
		if (refill_done) begin
			tag_mem[fill_index] <= fill_tag;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			valid <= '0;
		end else if (refill_done) begin
			valid[fill_index] <= 1'b1;
		end
	end

	// ******************************
	// Lookup
	// ******************************

	always_ff @(posedge clock) begin
		if (reset) begin
			rd_valid <= 1'b0;
		end else if (lookup_en) begin
			rd_valid <= valid[lookup_index];
		end
	end

	always_ff @(posedge clock) begin
		if (lookup_en) begin
			cache_rdata <= data_mem[lookup_index][lookup_word];
			rd_tag <= tag_mem[lookup_index];
			cmp_tag <= lookup_tag;
		end
	end

	assign hit = rd_valid && (rd_tag == cmp_tag); // Valid during the compare cycle.

endmodule

/* src/refill_counter.sv */
`timescale 1ns/1ps

module refill_counter import fetch_pkg::*; (
	input  logic  clock,
	input  logic  reset,
	input  logic  refill_start,
	input  logic  mem_rvalid,
	input  logic  mem_rlast,
	output beat_t beat_index,
	output logic  beat_write,
	output logic  refill_done
);

	logic active; // A line refill is in progress.
	beat_t count;

	// Every beat seen during a refill goes into the line.
	assign beat_write = active & mem_rvalid;
	assign refill_done = beat_write & mem_rlast;
	assign beat_index = count;

	// ******************************
	// Refill tracking
	// ******************************

	always_ff @(posedge clock) begin
		if (reset) begin
			active <= 1'b0;
		end else if (refill_start) begin
			active <= 1'b1;
		end else if (refill_done) begin
			active <= 1'b0;
		end
	end

	// Burst is incremental from the line base, so the word index simply counts up.
	always_ff @(posedge clock) begin
		if (reset) begin
			count <= '0;
		end else if (refill_start) begin
			count <= '0;
		end else if (beat_write) begin
			count <= count + 1'b1;
		end
	end

endmodule

/* src/fetch_control.sv */
`timescale 1ns/1ps

module fetch_control import fetch_pkg::*; (
	input  logic clock,
	input  logic reset,
	input  logic in_window,
	input  logic hit,
	input  logic mem_arready,
	input  logic mem_rvalid,
	input  logic refill_done,
	input  logic jump_wrong,
	input  logic idu_ready,
	output logic lookup_en,
	output logic refill_start,
	output logic ar_issue,
	output logic inst_load_cache,
	output logic inst_load_mem,
	output logic pc_advance,
	output logic idu_valid
);

	fetch_state_t state;
	fetch_state_t state_next;
	logic flush; // A redirect arrived while a read was in flight.
	logic drop; // The read finishing now must not be delivered.
	logic read_busy;

	assign read_busy = (state == s_refill_req) || (state == s_refill_data) ||
		(state == s_single_req) || (state == s_single_data);
	assign drop = flush | jump_wrong;

	// ******************************
	// State register
	// ******************************

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= s_idle;
		end else begin
			state <= state_next;
		end
	end

	// The flag lives until the state machine is back in lookup.
	always_ff @(posedge clock) begin
		if (reset) begin
			flush <= 1'b0;
		end else if (state_next == s_lookup) begin
			flush <= 1'b0;
		end else if (jump_wrong && read_busy) begin
			flush <= 1'b1;
		end
	end

	// ******************************
	// Next state and strobes
	// ******************************

	always_comb begin
		state_next = state;
		refill_start = 1'b0;
		inst_load_cache = 1'b0;
		inst_load_mem = 1'b0;
		pc_advance = 1'b0;
		case (state)
			s_idle: begin
				state_next = s_lookup;
			end
			s_lookup: begin
				if (jump_wrong) begin
					state_next = s_lookup; // Look up again at the new pc.
				end else if (in_window) begin
					state_next = s_compare;
				end else begin
					state_next = s_single_req;
				end
			end
			s_compare: begin
				if (jump_wrong) begin
					state_next = s_lookup;
				end else if (hit) begin
					inst_load_cache = 1'b1;
					state_next = s_deliver;
				end else begin
					refill_start = 1'b1;
					state_next = s_refill_req;
				end
			end
			s_refill_req: begin
				if (mem_arready) begin
					state_next = s_refill_data;
				end
			end
			s_refill_data: begin
				inst_load_mem = mem_rvalid; // Datapath picks the matching beat.
				if (refill_done) begin
					state_next = drop ? s_lookup : s_deliver;
				end
			end
			s_single_req: begin
				if (mem_arready) begin
					state_next = s_single_data;
				end
			end
			s_single_data: begin
				if (mem_rvalid) begin
					inst_load_mem = 1'b1;
					state_next = drop ? s_lookup : s_deliver;
				end
			end
			s_deliver: begin
				if (jump_wrong) begin
					state_next = s_lookup; // The held instruction is dropped.
				end else if (idu_ready) begin
					pc_advance = 1'b1;
					state_next = s_lookup;
				end
			end
			default: begin
				state_next = s_idle;
			end
		endcase
	end

	// Moore outputs, all taken straight from the state register.
	assign lookup_en = (state == s_lookup);
	assign ar_issue = (state == s_refill_req) || (state == s_single_req);
	assign idu_valid = (state == s_deliver);

endmodule

/* src/fetch_pkg.sv */
package fetch_pkg;

	// ******************************
	// Widths with a meaning
	// ******************************

	typedef logic [31:0] addr_t; // Byte address.
	typedef logic [31:0] word_t; // Instruction or data word.
	typedef logic [1:0] burst_t; // AXI burst type.
	typedef logic [3:0] len_t; // AXI beat count minus one.
	typedef logic [1:0] beat_t; // Word index within a cache line.

	// ******************************
	// Fetch sequencing
	// ******************************

	typedef enum logic [2:0] {
		s_idle,
		s_lookup,
		s_compare,
		s_refill_req,
		s_refill_data,
		s_single_req,
		s_single_data,
		s_deliver
	} fetch_state_t;

	// Burst codes as they appear on the read address channel.
	localparam burst_t burst_fixed = 2'd0;
	localparam burst_t burst_incr = 2'd1;

	// A line is four words, so a refill is a four beat burst.
	localparam len_t line_len = 4'd3;

endpackage
